// File: common/ycr_defines.svh
/*
 * Shared macros for the core top level
 *   Hart and DMI word widths
 *   DMI request queue depth and reset status synchronizer depth
 *   DMI register addresses of the debug module
 */

`ifndef YCR_DEFINES_SVH
`define YCR_DEFINES_SVH

// Widths ----------------------------------------
`define YCR_XLEN                32      // Hart register width
`define YCR_DMI_ADDR_WIDTH      7       // DMI address bus
`define YCR_DMI_DATA_WIDTH      32      // DMI data bus

// Depths ----------------------------------------
`define YCR_DMI_FIFO_DEPTH      2       // Also the host's initial credit count
`define YCR_RST_SYNC_STAGES     2       // Core reset status sync flops

// DMI register map ------------------------------
`define YCR_DMI_ADDR_DATA0      7'h04   // Scratch data
`define YCR_DMI_ADDR_DMCONTROL  7'h10   // Debug module control
`define YCR_DMI_ADDR_HARTID     7'h11   // Fused hart id, read only

`endif // YCR_DEFINES_SVH

// File: common/ycr_dbg_pkg.sv
/*
 * Debug transport types
 *   DMCONTROL field layout
 *   DMI data word union (raw or DMCONTROL)
 *   DMI request and response structs
 */

`include "ycr_defines.svh"

package ycr_dbg_pkg;

    //--------------------------------------------------
    // DMCONTROL register layout
    //--------------------------------------------------
    typedef struct packed {
        logic           haltreq;    // Bit 31
        logic [28:0]    rsvd;       // Reads as zero
        logic           ndmreset;   // Bit 1, non-debug-module reset
        logic           dmactive;   // Bit 0
    } dmcontrol_s;

    // Same DMI word, decoded per register
    typedef union packed {
        logic [`YCR_DMI_DATA_WIDTH-1:0] raw;        // Plain data view
        dmcontrol_s                     dmcontrol;  // DMCONTROL view
    } dmi_data_u;

    //--------------------------------------------------
    // DMI transport
    //--------------------------------------------------

    // Host to DM, 40 bits
    typedef struct packed {
        logic                           wr;     // 1 write, 0 read
        logic [`YCR_DMI_ADDR_WIDTH-1:0] addr;   // Register address
        dmi_data_u                      data;   // Write data
    } dmi_req_s;

    // DM to host, 33 bits
    typedef struct packed {
        logic                           err;    // Access failed
        logic [`YCR_DMI_DATA_WIDTH-1:0] rdata;  // Read data
    } dmi_resp_s;

endpackage : ycr_dbg_pkg

// File: common/ycr_rst_pkg.sv
/*
 * Reset control types
 *   Per-domain reset bundle from the qualifier adapter
 *   Core reset status as seen outside the SCU
 */

package ycr_rst_pkg;

    // One reset domain, as produced by the adapter
    typedef struct packed {
        logic   rst_n;          // Domain reset, active low
        logic   rdc_qlfy;       // RDC qualifier, low masks crossings
        logic   rst_n_status;   // Raw status, unsynchronized
    } rst_qlfy_s;

    // Core reset status on the top level
    typedef struct packed {
        logic   core_rst_status;    // 1 while core is in reset
        logic   core_rdc_qlfy;      // Core RDC qualifier
    } rst_status_s;

endpackage : ycr_rst_pkg

// File: scu/ycr_reset_qlfy_adapter.sv
/*
 * Reset qualifier adapter
 *   Registers a combined reset request
 *   Orders reset and RDC qualifier around assert and release
 *   Test-mode reset bypass on the reset output
 */

module ycr_reset_qlfy_adapter (
    input  logic                    clk,            // Core clock
    input  logic                    rst_n_i,        // Power-up reset
    input  logic                    test_mode_i,    // DFT test mode
    input  logic                    test_rst_n_i,   // DFT test reset
    input  logic                    rst_req_n_i,    // Combined request, active low
    output ycr_rst_pkg::rst_qlfy_s  rst_o           // Reset, qualifier, status
);

logic   req_ff;     // Sampled request
logic   qlfy_ff;    // RDC qualifier
logic   rst_ff;     // Reset before test mux

//--------------------------------------------------
// Sequencing
//--------------------------------------------------
// Assert   qualifier drops first, reset one cycle later
// Release  reset rises first, qualifier one cycle later
always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
        req_ff  <= 1'b0;
        qlfy_ff <= 1'b0;
        rst_ff  <= 1'b0;
    end else begin
        req_ff  <= rst_req_n_i;
        qlfy_ff <= req_ff & rst_ff;                 // Low while either is low
        rst_ff  <= req_ff | (rst_ff & qlfy_ff);     // Holds until qualifier is down
    end
end

// Short request pulses never reach rst_ff, only the qualifier blinks

//--------------------------------------------------
// Outputs
//--------------------------------------------------
assign rst_o.rst_n        = test_mode_i ? test_rst_n_i : rst_ff;   // DFT bypass
assign rst_o.rdc_qlfy     = qlfy_ff;
assign rst_o.rst_n_status = rst_ff;                                // Raw, needs sync

endmodule : ycr_reset_qlfy_adapter

// File: scu/ycr_scu.sv
/*
 * System control unit
 *   Merges regular, CPU and debug resets into the core request
 *   Core reset generation through the qualifier adapter
 *   Synchronized core reset status
 */

`include "ycr_defines.svh"

module ycr_scu (
    input  logic                        clk,            // Core clock
    input  logic                        rst_n_i,        // Power-up reset
    input  logic                        sys_rst_n_i,    // Regular reset
    input  logic                        cpu_rst_n_i,    // CPU reset
    input  logic                        ndmreset_i,     // Debug request, active high
    input  logic                        test_mode_i,    // DFT test mode
    input  logic                        test_rst_n_i,   // DFT test reset
    output logic                        core_rst_n_o,   // Core reset
    output ycr_rst_pkg::rst_status_s    status_o        // Status and qualifier
);

localparam int unsigned SYNC_STAGES = `YCR_RST_SYNC_STAGES;

logic                       core_req_n;     // Any source asks for reset
ycr_rst_pkg::rst_qlfy_s     core_rst;       // Adapter bundle
logic [SYNC_STAGES-1:0]     status_sync;    // Status shift register

//--------------------------------------------------
// Core reset
//--------------------------------------------------
assign core_req_n = sys_rst_n_i & cpu_rst_n_i & ~ndmreset_i;

ycr_reset_qlfy_adapter i_core_rst_adapter (
    .clk            (clk            ),
    .rst_n_i        (rst_n_i        ),
    .test_mode_i    (test_mode_i    ),
    .test_rst_n_i   (test_rst_n_i   ),
    .rst_req_n_i    (core_req_n     ),
    .rst_o          (core_rst       )
);

//--------------------------------------------------
// Status synchronizer
//--------------------------------------------------
// Resets to 0, so status reads "in reset" until released
always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
        status_sync <= '0;
    end else begin
        status_sync[0] <= core_rst.rst_n_status;
        for (int i = 1; i < SYNC_STAGES; i++) begin
            status_sync[i] <= status_sync[i-1];     // Shift toward output
        end
    end
end

assign core_rst_n_o             = core_rst.rst_n;
assign status_o.core_rst_status = ~status_sync[SYNC_STAGES-1];    // 1 means held in reset
assign status_o.core_rdc_qlfy   = core_rst.rdc_qlfy;

endmodule : ycr_scu

// File: dm/ycr_dmi_fifo.sv
/*
 * DMI request queue
 *   Circular buffer with read and write pointers
 *   Head pops every cycle it is valid
 *   One credit back to the host per pop
 */

`include "ycr_defines.svh"

module ycr_dmi_fifo (
    input  logic                    clk,            // Core clock
    input  logic                    rst_n_i,        // Power-up reset
    input  logic                    req_valid_i,    // Host request strobe
    input  ycr_dbg_pkg::dmi_req_s   req_i,          // Host request
    output logic                    head_valid_o,   // Head present
    output ycr_dbg_pkg::dmi_req_s   head_o,         // Head entry
    output logic                    credit_o        // Credit return pulse
);

localparam int unsigned DEPTH = `YCR_DMI_FIFO_DEPTH;
localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
localparam int unsigned CNT_W = $clog2(DEPTH + 1);

ycr_dbg_pkg::dmi_req_s  mem [DEPTH];    // Entry storage
logic [PTR_W-1:0]       wr_ptr;
logic [PTR_W-1:0]       rd_ptr;
logic [CNT_W-1:0]       count;          // Entries held
logic                   push;
logic                   pop;
logic                   full;

//--------------------------------------------------
// Control
//--------------------------------------------------
assign full = (count == CNT_W'(DEPTH));
assign push = req_valid_i & ~full;      // Overflow only if host ignores credits
assign pop  = head_valid_o;             // DM never stalls

always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        count  <= '0;
    end else begin
        if (push) begin
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;   // Wrap
        end
        if (pop) begin
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
        end
        case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;        // Both or neither
        endcase
    end
end

//--------------------------------------------------
// Storage
//--------------------------------------------------
always_ff @(posedge clk) begin
    if (push) begin
        mem[wr_ptr] <= req_i;
    end
end

assign head_valid_o = (count != '0);
assign head_o       = mem[rd_ptr];
assign credit_o     = pop;              // Slot freed this cycle

endmodule : ycr_dmi_fifo

// File: dm/ycr_dm.sv
/*
 * Debug module register set
 *   DMCONTROL with dmactive, ndmreset, haltreq
 *   DATA0 scratch register, writable while active
 *   HARTID from fuses, read only
 *   One response per request, one cycle later
 */

`include "ycr_defines.svh"

module ycr_dm (
    input  logic                        clk,            // Core clock
    input  logic                        rst_n_i,        // Power-up reset
    input  logic                        req_valid_i,    // Queue head valid
    input  ycr_dbg_pkg::dmi_req_s       req_i,          // Queue head
    input  logic [`YCR_XLEN-1:0]        fuse_mhartid_i, // Fused hart id
    output logic                        resp_valid_o,   // Response strobe
    output ycr_dbg_pkg::dmi_resp_s      resp_o,         // Response
    output logic                        ndmreset_o,     // Reset request to SCU
    output logic                        haltreq_o       // Halt request to hart
);

logic                               dmactive_q;
logic                               ndmreset_q;
logic                               haltreq_q;
logic [`YCR_DMI_DATA_WIDTH-1:0]     data0_q;
ycr_dbg_pkg::dmcontrol_s            dmcontrol_rd;   // Read view of DMCONTROL
ycr_dbg_pkg::dmi_resp_s             resp_d;
logic                               dmcontrol_we;
logic                               data0_we;

//--------------------------------------------------
// Address decode
//--------------------------------------------------
always_comb begin
    dmcontrol_rd          = '0;             // Reserved bits read as zero
    dmcontrol_rd.haltreq  = haltreq_q;
    dmcontrol_rd.ndmreset = ndmreset_q;
    dmcontrol_rd.dmactive = dmactive_q;

    resp_d       = '0;
    dmcontrol_we = 1'b0;
    data0_we     = 1'b0;

    case (req_i.addr)
        `YCR_DMI_ADDR_DMCONTROL: begin
            resp_d.rdata = dmcontrol_rd;
            dmcontrol_we = req_i.wr;
        end
        `YCR_DMI_ADDR_DATA0: begin
            resp_d.rdata = data0_q;
            if (req_i.wr) begin
                if (dmactive_q) begin
                    data0_we = 1'b1;
                end else begin
                    resp_d.err = 1'b1;      // Locked while inactive
                end
            end
        end
        `YCR_DMI_ADDR_HARTID: begin
            resp_d.rdata = fuse_mhartid_i;  // Writes dropped silently
        end
        default: begin
            resp_d.err = 1'b1;              // Unmapped, rdata stays 0
        end
    endcase
end

//--------------------------------------------------
// Registers
//--------------------------------------------------
// Power-up domain only, state survives core reset
always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
        dmactive_q <= 1'b0;
        ndmreset_q <= 1'b0;
        haltreq_q  <= 1'b0;
        data0_q    <= '0;
    end else begin
        if (req_valid_i && dmcontrol_we) begin
            dmactive_q <= req_i.data.dmcontrol.dmactive;
            // Deactivating clears the requests
            ndmreset_q <= req_i.data.dmcontrol.ndmreset & req_i.data.dmcontrol.dmactive;
            haltreq_q  <= req_i.data.dmcontrol.haltreq & req_i.data.dmcontrol.dmactive;
        end
        if (req_valid_i && data0_we) begin
            data0_q <= req_i.data.raw;
        end
    end
end

// Response strobe
always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
        resp_valid_o <= 1'b0;
    end else begin
        resp_valid_o <= req_valid_i;
    end
end

always_ff @(posedge clk) begin
    if (req_valid_i) begin
        resp_o <= resp_d;                   // Held until next request
    end
end

assign ndmreset_o = ndmreset_q;
assign haltreq_o  = haltreq_q;

endmodule : ycr_dm

// File: hw/ycr_core_top.sv
/*
 * Core top level, reset and debug access
 *   SCU for core reset and its status
 *   DMI request queue with credit return
 *   Debug module register set
 */

`include "ycr_defines.svh"

module ycr_core_top (
    // Common
    input  logic                        clk,                    // Core clock
    input  logic                        rst_n_i,                // Power-up reset
    input  logic                        sys_rst_n_i,            // Regular reset
    input  logic                        cpu_rst_n_i,            // CPU reset
    input  logic                        test_mode_i,            // DFT test mode
    input  logic                        test_rst_n_i,           // DFT test reset
    input  logic [`YCR_XLEN-1:0]        core_fuse_mhartid_i,    // Fused hart id

    // DMI host port
    input  logic                        dmi_req_valid_i,        // Request strobe
    input  ycr_dbg_pkg::dmi_req_s       dmi_req_i,              // Request
    output logic                        dmi_credit_o,           // Credit return
    output logic                        dmi_resp_valid_o,       // Response strobe
    output ycr_dbg_pkg::dmi_resp_s      dmi_resp_o,             // Response

    // Reset and debug status
    output logic                        core_rst_n_o,           // Core reset
    output ycr_rst_pkg::rst_status_s    core_status_o,          // Core reset status
    output logic                        dbg_haltreq_o           // Halt request
);

logic                       dmi_head_valid; // Queue to DM
ycr_dbg_pkg::dmi_req_s      dmi_head;
logic                       dm_ndmreset;    // DM to SCU

//--------------------------------------------------
// Reset control
//--------------------------------------------------
ycr_scu i_scu (
    .clk            (clk            ),
    .rst_n_i        (rst_n_i        ),
    .sys_rst_n_i    (sys_rst_n_i    ),
    .cpu_rst_n_i    (cpu_rst_n_i    ),
    .ndmreset_i     (dm_ndmreset    ),
    .test_mode_i    (test_mode_i    ),
    .test_rst_n_i   (test_rst_n_i   ),
    .core_rst_n_o   (core_rst_n_o   ),
    .status_o       (core_status_o  )
);

//--------------------------------------------------
// Debug access
//--------------------------------------------------
ycr_dmi_fifo i_dmi_fifo (
    .clk            (clk            ),
    .rst_n_i        (rst_n_i        ),
    .req_valid_i    (dmi_req_valid_i),
    .req_i          (dmi_req_i      ),
    .head_valid_o   (dmi_head_valid ),
    .head_o         (dmi_head       ),
    .credit_o       (dmi_credit_o   )
);

// Stays on power-up reset across core resets
ycr_dm i_dm (
    .clk            (clk                ),
    .rst_n_i        (rst_n_i            ),
    .req_valid_i    (dmi_head_valid     ),
    .req_i          (dmi_head           ),
    .fuse_mhartid_i (core_fuse_mhartid_i),
    .resp_valid_o   (dmi_resp_valid_o   ),
    .resp_o         (dmi_resp_o         ),
    .ndmreset_o     (dm_ndmreset        ),
    .haltreq_o      (dbg_haltreq_o      )
);

endmodule : ycr_core_top

// File: verif/ycr_core_assertions.sv
/*
 * Concurrent checks on the core top level
 *   Host never holds more requests than the queue depth
 *   Response two cycles after a request into an empty queue
 *   RDC qualifier low whenever the core is in reset
 */

`include "ycr_defines.svh"

module ycr_core_assertions (
    input  logic                        clk,                // Core clock
    input  logic                        rst_n_i,            // Power-up reset
    input  logic                        test_mode_i,        // DFT test mode
    input  logic                        dmi_req_valid_i,    // Host request strobe
    input  logic                        dmi_head_valid_i,   // Queue not empty
    input  logic                        dmi_credit_i,       // Credit return pulse
    input  logic                        dmi_resp_valid_i,   // Response strobe
    input  logic                        core_rst_n_i,       // Core reset
    input  ycr_rst_pkg::rst_status_s    core_status_i       // Core reset status
);

timeunit 1ns;
timeprecision 1ps;

logic [3:0] outstanding;    // Requests sent minus credits returned

always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
        outstanding <= '0;
    end else begin
        outstanding <= outstanding + dmi_req_valid_i - dmi_credit_i;
    end
end

// Credit overflow
credit_limit_a : assert property (@(posedge clk) disable iff (!rst_n_i)
    outstanding <= `YCR_DMI_FIFO_DEPTH)
    else $error("more requests outstanding than queue slots");

// Empty queue latency
resp_latency_a : assert property (@(posedge clk) disable iff (!rst_n_i)
    (dmi_req_valid_i && !dmi_head_valid_i) |-> ##2 dmi_resp_valid_i)
    else $error("response did not follow request after two cycles");

// Crossings masked while the core is held
rdc_qlfy_a : assert property (@(posedge clk) disable iff (!rst_n_i)
    (!core_rst_n_i && !test_mode_i) |-> !core_status_i.core_rdc_qlfy)
    else $error("qualifier high while core reset is asserted");

endmodule : ycr_core_assertions

bind ycr_core_top ycr_core_assertions i_core_assertions (
    .clk                (clk                ),
    .rst_n_i            (rst_n_i            ),
    .test_mode_i        (test_mode_i        ),
    .dmi_req_valid_i    (dmi_req_valid_i    ),
    .dmi_head_valid_i   (dmi_head_valid     ),
    .dmi_credit_i       (dmi_credit_o       ),
    .dmi_resp_valid_i   (dmi_resp_valid_o   ),
    .core_rst_n_i       (core_rst_n_o       ),
    .core_status_i      (core_status_o      )
);

// File: verif/tb_ycr_core_top.sv
/*
 * Directed testbench for the core top level
 *   Clock, power-up reset and DMI host model with credit counter
 *   Compare tasks for DMI responses, reset status and single bits
 *   Tests for reset, DM registers, pipelining, ndmreset and test mode
 */

`include "ycr_defines.svh"

module tb_ycr_core_top;

timeunit 1ns;
timeprecision 1ps;

localparam int TIMEOUT = 50;        // Cycles per wait loop
localparam logic [31:0] FUSE_ID = 32'h0000_0a5c;

logic                       clk;
logic                       rst_n_i;
logic                       sys_rst_n_i;
logic                       cpu_rst_n_i;
logic                       test_mode_i;
logic                       test_rst_n_i;
logic [`YCR_XLEN-1:0]       core_fuse_mhartid_i;
logic                       dmi_req_valid_i;
ycr_dbg_pkg::dmi_req_s      dmi_req_i;
logic                       dmi_credit_o;
logic                       dmi_resp_valid_o;
ycr_dbg_pkg::dmi_resp_s     dmi_resp_o;
logic                       core_rst_n_o;
ycr_rst_pkg::rst_status_s   core_status_o;
logic                       dbg_haltreq_o;

int                         credits;        // Host side credit count
ycr_dbg_pkg::dmi_resp_s     resp_q[$];      // Responses in arrival order
integer                     seed;

ycr_core_top i_dut (.*);

always #10 clk = ~clk;              // 20 ns period

// Host model -------------------------------------
task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("Checks failed");
    $fatal(1);
endtask

// One cycle sampled at the falling edge
task automatic step();
    @(negedge clk);
    if (rst_n_i && dmi_credit_o) credits++;
    if (rst_n_i && dmi_resp_valid_o) resp_q.push_back(dmi_resp_o);
endtask

task automatic send_req(input logic wr, input logic [6:0] addr, input logic [31:0] data);
    ycr_dbg_pkg::dmi_req_s req;
    int                    n;
    n = 0;
    while (credits == 0) begin          // Host may not send without credit
        step();
        if (++n > TIMEOUT) stop_on_error("no DMI credit came back");
    end
    req.wr          = wr;
    req.addr        = addr;
    req.data.raw    = data;
    dmi_req_i       = req;
    dmi_req_valid_i = 1'b1;
    credits--;
    step();
    dmi_req_valid_i = 1'b0;
endtask

task automatic wait_resp(output ycr_dbg_pkg::dmi_resp_s resp);
    int n;
    n = 0;
    while (resp_q.size() == 0) begin
        step();
        if (++n > TIMEOUT) stop_on_error("DMI response never arrived");
    end
    resp = resp_q.pop_front();
endtask

task automatic dmi_access(input logic wr, input logic [6:0] addr, input logic [31:0] data,
                          output ycr_dbg_pkg::dmi_resp_s resp);
    send_req(wr, addr, data);
    wait_resp(resp);
endtask

function automatic ycr_dbg_pkg::dmi_resp_s make_resp(input logic err, input logic [31:0] rdata);
    ycr_dbg_pkg::dmi_resp_s r;
    r.err   = err;
    r.rdata = rdata;
    return r;
endfunction

function automatic ycr_rst_pkg::rst_status_s make_status(input logic in_rst, input logic qlfy);
    ycr_rst_pkg::rst_status_s s;
    s.core_rst_status = in_rst;
    s.core_rdc_qlfy   = qlfy;
    return s;
endfunction

// Compare tasks ----------------------------------
task automatic check_resp(input string name, input ycr_dbg_pkg::dmi_resp_s exp,
                          input ycr_dbg_pkg::dmi_resp_s act);
    if (act !== exp) stop_on_error($sformatf(
        "FAIL %s: expected err=%0b rdata=%h, actual err=%0b rdata=%h",
        name, exp.err, exp.rdata, act.err, act.rdata));
endtask

task automatic check_status(input string name, input ycr_rst_pkg::rst_status_s exp,
                            input ycr_rst_pkg::rst_status_s act);
    if (act !== exp) stop_on_error($sformatf(
        "FAIL %s: expected status=%0b qlfy=%0b, actual status=%0b qlfy=%0b",
        name, exp.core_rst_status, exp.core_rdc_qlfy, act.core_rst_status, act.core_rdc_qlfy));
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) stop_on_error($sformatf("FAIL %s: expected %0b, actual %0b",
                                             name, exp, act));
endtask

task automatic wait_core_rst(input logic exp);
    int n;
    n = 0;
    while (core_rst_n_o !== exp) begin
        step();
        if (++n > TIMEOUT) stop_on_error("core reset did not reach the expected level");
    end
endtask

task automatic wait_status(input ycr_rst_pkg::rst_status_s exp);
    int n;
    n = 0;
    while (core_status_o !== exp) begin
        step();
        if (++n > TIMEOUT) stop_on_error("core reset status did not settle");
    end
endtask

// Tests ------------------------------------------
task automatic test_reset_values();
    repeat (5) step();                          // Power-up reset held
    check_status("status in reset", make_status(1'b1, 1'b0), core_status_o);
    rst_n_i = 1'b1;
    repeat (6) step();                          // CPU reset still held
    check_bit("core held by cpu reset", 1'b0, core_rst_n_o);
    check_status("status under cpu reset", make_status(1'b1, 1'b0), core_status_o);
    cpu_rst_n_i = 1'b1;
    wait_core_rst(1'b1);
    wait_status(make_status(1'b0, 1'b1));
    check_bit("no response after reset", 1'b0, dmi_resp_valid_o);
    check_bit("no credit after reset", 1'b0, dmi_credit_o);
    check_bit("no haltreq after reset", 1'b0, dbg_haltreq_o);
endtask

task automatic test_data0_rules();
    ycr_dbg_pkg::dmi_resp_s resp;
    logic [31:0]            val;
    dmi_access(1'b1, `YCR_DMI_ADDR_DATA0, 32'hdead_beef, resp);
    check_bit("data0 write while inactive err", 1'b1, resp.err);
    dmi_access(1'b0, `YCR_DMI_ADDR_DATA0, '0, resp);
    check_resp("data0 unchanged while inactive", make_resp(1'b0, '0), resp);
    dmi_access(1'b1, `YCR_DMI_ADDR_DMCONTROL, 32'h1, resp);    // dmactive
    check_bit("dmcontrol write err", 1'b0, resp.err);
    dmi_access(1'b0, `YCR_DMI_ADDR_DMCONTROL, '0, resp);
    check_resp("dmcontrol readback", make_resp(1'b0, 32'h1), resp);
    repeat (4) begin
        val = $random(seed);
        dmi_access(1'b1, `YCR_DMI_ADDR_DATA0, val, resp);
        check_bit("data0 write err", 1'b0, resp.err);
        dmi_access(1'b0, `YCR_DMI_ADDR_DATA0, '0, resp);
        check_resp("data0 readback", make_resp(1'b0, val), resp);
    end
endtask

task automatic test_readonly_unknown();
    ycr_dbg_pkg::dmi_resp_s resp;
    dmi_access(1'b0, `YCR_DMI_ADDR_HARTID, '0, resp);
    check_resp("hartid read", make_resp(1'b0, FUSE_ID), resp);
    dmi_access(1'b1, `YCR_DMI_ADDR_HARTID, 32'h1234_5678, resp);
    check_bit("hartid write err", 1'b0, resp.err);             // Dropped silently
    dmi_access(1'b0, `YCR_DMI_ADDR_HARTID, '0, resp);
    check_resp("hartid after write", make_resp(1'b0, FUSE_ID), resp);
    dmi_access(1'b0, 7'h7f, '0, resp);
    check_resp("unknown read", make_resp(1'b1, '0), resp);
    dmi_access(1'b1, 7'h22, 32'hffff_ffff, resp);
    check_resp("unknown write", make_resp(1'b1, '0), resp);
endtask

task automatic test_credits_pipeline(output logic [31:0] last);
    ycr_dbg_pkg::dmi_resp_s resp;
    logic [31:0]            a;
    logic [31:0]            b;
    int                     n;
    a = $random(seed);
    b = $random(seed);
    send_req(1'b1, `YCR_DMI_ADDR_DATA0, a);     // Four requests, two credits
    send_req(1'b0, `YCR_DMI_ADDR_DATA0, '0);
    send_req(1'b1, `YCR_DMI_ADDR_DATA0, b);
    send_req(1'b0, `YCR_DMI_ADDR_DATA0, '0);
    wait_resp(resp);
    check_bit("pipelined write a err", 1'b0, resp.err);
    wait_resp(resp);
    check_resp("pipelined read a", make_resp(1'b0, a), resp);
    wait_resp(resp);
    check_bit("pipelined write b err", 1'b0, resp.err);
    wait_resp(resp);
    check_resp("pipelined read b", make_resp(1'b0, b), resp);
    n = 0;
    while (credits != `YCR_DMI_FIFO_DEPTH) begin
        step();
        if (++n > TIMEOUT) stop_on_error("host credits did not return to the queue depth");
    end
    last = b;
endtask

task automatic test_ndmreset(input logic [31:0] data0);
    ycr_dbg_pkg::dmi_resp_s resp;
    dmi_access(1'b1, `YCR_DMI_ADDR_DMCONTROL, 32'h3, resp);    // ndmreset + dmactive
    wait_core_rst(1'b0);
    wait_status(make_status(1'b1, 1'b0));
    dmi_access(1'b0, `YCR_DMI_ADDR_DATA0, '0, resp);
    check_resp("data0 kept over core reset", make_resp(1'b0, data0), resp);
    dmi_access(1'b1, `YCR_DMI_ADDR_DMCONTROL, 32'h1, resp);
    wait_core_rst(1'b1);
    wait_status(make_status(1'b0, 1'b1));
    dmi_access(1'b1, `YCR_DMI_ADDR_DMCONTROL, 32'h8000_0001, resp);
    check_bit("haltreq set", 1'b1, dbg_haltreq_o);
    dmi_access(1'b0, `YCR_DMI_ADDR_DMCONTROL, '0, resp);
    check_resp("dmcontrol with haltreq", make_resp(1'b0, 32'h8000_0001), resp);
    dmi_access(1'b1, `YCR_DMI_ADDR_DMCONTROL, 32'h8000_0000, resp);  // Deactivate
    check_bit("haltreq cleared by dmactive 0", 1'b0, dbg_haltreq_o);
endtask

task automatic test_mode_reset();
    test_mode_i = 1'b1;
    step();
    check_bit("test reset high", 1'b1, core_rst_n_o);
    test_rst_n_i = 1'b0;
    step();
    check_bit("test reset low", 1'b0, core_rst_n_o);
    test_rst_n_i = 1'b1;
    step();
    check_bit("test reset released", 1'b1, core_rst_n_o);
    test_mode_i = 1'b0;
    step();
    check_bit("functional reset back", 1'b1, core_rst_n_o);
endtask

initial begin
    logic [31:0] data0;
    clk                 = 1'b0;
    rst_n_i             = 1'b0;
    sys_rst_n_i         = 1'b1;
    cpu_rst_n_i         = 1'b0;
    test_mode_i         = 1'b0;
    test_rst_n_i        = 1'b1;
    core_fuse_mhartid_i = FUSE_ID;
    dmi_req_valid_i     = 1'b0;
    dmi_req_i           = '0;
    credits             = `YCR_DMI_FIFO_DEPTH;
    seed                = 32'h3c4b4eb0;

    test_reset_values();
    test_data0_rules();
    test_readonly_unknown();
    test_credits_pipeline(data0);
    test_ndmreset(data0);
    test_mode_reset();

    $display("All checks passed");
    $finish;
end

endmodule : tb_ycr_core_top

// File: verilog.f
+incdir+common
common/ycr_dbg_pkg.sv
common/ycr_rst_pkg.sv
scu/ycr_reset_qlfy_adapter.sv
scu/ycr_scu.sv
dm/ycr_dmi_fifo.sv
dm/ycr_dm.sv
hw/ycr_core_top.sv
verif/ycr_core_assertions.sv
verif/tb_ycr_core_top.sv
